// ==== project.f ====
cp0_pkg.sv
cp0_regfile.sv
cp0_write_arbiter.sv
exc_entry.sv
tlb_result_writer.sv
cp0_top.sv
tb_clock_gen.sv
cp0_tb.sv

// ==== Bender.yml ====
package:
  name: cp0

sources:
  - cp0_pkg.sv
  - cp0_regfile.sv
  - cp0_write_arbiter.sv
  - exc_entry.sv
  - tlb_result_writer.sv
  - cp0_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - cp0_tb.sv

// ==== cp0_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;
	import cp0_pkg::*;

	localparam word_t BASE = 32'hbfc0_0200;
	localparam int COUNT_DIV = 2;
	localparam int MAX_CYCLES = 2000;
	localparam word_t BEV = 32'h0040_0000;

	logic clk;
	logic reset;
	logic mtc0_valid;
	cp0_addr_t mtc0_addr;
	word_t mtc0_data;
	cp0_addr_t rd_addr;
	cp0_addr_t rdm_addr;
	logic exc_valid;
	excp_flags_t excp_flags;
	word_t pc;
	word_t vaddr;
	logic is_slot;
	logic d_write;
	logic eret;
	logic [5:0] ext_int;
	logic inter_valid;
	word_t int_pc;
	logic int_slot;
	logic tlb_valid;
	tlb_op_t tlb_op;
	word_t res_index;
	word_t res_entry_hi;
	word_t res_entry_lo0;
	word_t res_entry_lo1;
	word_t rd_data;
	word_t rdm_data;
	word_t epc;
	word_t entrance;
	exc_code_t exc_code;
	logic exc_taken;
	logic exc_busy;
	logic tlb_busy;
	logic mtc0_stall;
	word_t lcg_state;
	int cycles = 0;

	tb_clock_gen #(
		.PERIOD(8.0),
		.RESET_CYCLES(5)
	) i_clock (
		.clk(clk),
		.reset(reset)
	);

	cp0_top #(
		.EXC_BASE(BASE),
		.COUNT_DIV(COUNT_DIV)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.mtc0_valid(mtc0_valid),
		.mtc0_addr(mtc0_addr),
		.mtc0_data(mtc0_data),
		.rd_addr(rd_addr),
		.rdm_addr(rdm_addr),
		.exc_valid(exc_valid),
		.excp_flags(excp_flags),
		.pc(pc),
		.vaddr(vaddr),
		.is_slot(is_slot),
		.d_write(d_write),
		.eret(eret),
		.ext_int(ext_int),
		.inter_valid(inter_valid),
		.int_pc(int_pc),
		.int_slot(int_slot),
		.tlb_valid(tlb_valid),
		.tlb_op(tlb_op),
		.res_index(res_index),
		.res_entry_hi(res_entry_hi),
		.res_entry_lo0(res_entry_lo0),
		.res_entry_lo1(res_entry_lo1),
		.rd_data(rd_data),
		.rdm_data(rdm_data),
		.epc(epc),
		.entrance(entrance),
		.exc_code(exc_code),
		.exc_taken(exc_taken),
		.exc_busy(exc_busy),
		.tlb_busy(tlb_busy),
		.mtc0_stall(mtc0_stall)
	);

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
		string line;
		if (actual !== expected) begin
			line = $sformatf("FAILED time=%0t signal=%s got=%h expected=%h",
				$time, name, actual, expected);
			fail_now(line);
		end
	endtask

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			fail_now("timeout, the tests did not finish in time");
		end
	end

	// holds the request until the arbiter lets it through
	task automatic mtc0_write(input cp0_addr_t a, input word_t d);
		@(negedge clk);
		mtc0_valid = 1'b1;
		mtc0_addr = a;
		mtc0_data = d;
		#1;
		while (mtc0_stall) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		mtc0_valid = 1'b0;
	endtask

	task automatic read_check(input cp0_addr_t a, input word_t expected);
		@(negedge clk);
		rd_addr = a;
		rdm_addr = a;
		#1;
		check($sformatf("rd_data[%h]", a), rd_data, expected);
		check($sformatf("rdm_data[%h]", a), rdm_data, expected);
	endtask

	task automatic read_word(input cp0_addr_t a, output word_t v);
		@(negedge clk);
		rd_addr = a;
		#1;
		v = rd_data;
	endtask

	task automatic wait_entry_done();
		while (exc_busy) begin
			@(negedge clk);
		end
	endtask

	task automatic do_eret();
		@(negedge clk);
		eret = 1'b1;
		@(negedge clk);
		eret = 1'b0;
		@(negedge clk);
	endtask

	task automatic test_mtc0_read();
		word_t lo0;
		word_t epc_val;
		word_t st;
		word_t ca;
		lo0 = lcg_next();
		epc_val = lcg_next();
		// keep ie clear so nothing gets latched as pending
		st = lcg_next() & ~32'h0000_0001;
		ca = lcg_next();
		mtc0_write(CP0_ENTRY_LO0, lo0);
		mtc0_write(CP0_EPC, epc_val);
		mtc0_write(CP0_STATUS, st);
		mtc0_write(CP0_CAUSE, ca);
		read_check(CP0_ENTRY_LO0, lo0);
		read_check(CP0_EPC, epc_val);
		read_check(CP0_STATUS, st & MASK_STATUS);
		read_check(CP0_CAUSE, ca & MASK_CAUSE);
		read_check(CP0_PRID, 32'h0000_4220);
		read_check(CP0_CONFIG0, 32'h8000_0480);
		read_check({5'd1, 3'd0}, 32'h0);
		// two ports on different registers at once
		@(negedge clk);
		rd_addr = CP0_ENTRY_LO0;
		rdm_addr = CP0_EPC;
		#1;
		check("rd_data", rd_data, lo0);
		check("rdm_data", rdm_data, epc_val);
		mtc0_write(CP0_STATUS, BEV);
		mtc0_write(CP0_CAUSE, 32'h0);
	endtask

	task automatic test_exception();
		word_t pc1;
		word_t pc2;
		word_t bad;
		word_t v;
		pc1 = lcg_next() & ~32'h3;
		pc2 = lcg_next() & ~32'h3;
		bad = lcg_next();
		// overflow outranks syscall
		@(negedge clk);
		exc_valid = 1'b1;
		excp_flags = '0;
		excp_flags[FLG_OV] = 1'b1;
		excp_flags[FLG_SYS] = 1'b1;
		pc = pc1;
		is_slot = 1'b1;
		#1;
		check("exc_taken", exc_taken, 1);
		check("exc_code", exc_code, 12);
		check("entrance", entrance, BASE + 32'h180);
		@(negedge clk);
		exc_valid = 1'b0;
		excp_flags = '0;
		is_slot = 1'b0;
		#1;
		check("exc_busy", exc_busy, 1);
		wait_entry_done();
		check("epc", epc, pc1 - 32'd4);
		read_check(CP0_EPC, pc1 - 32'd4);
		read_check(CP0_CAUSE, 32'h8000_0030);
		read_check(CP0_STATUS, BEV | 32'h2);
		// nested store address error, exl already set
		@(negedge clk);
		exc_valid = 1'b1;
		excp_flags = '0;
		excp_flags[FLG_ADES] = 1'b1;
		pc = pc2;
		vaddr = bad;
		d_write = 1'b1;
		#1;
		check("exc_taken", exc_taken, 1);
		check("exc_code", exc_code, 5);
		check("entrance", entrance, BASE + 32'h180);
		@(negedge clk);
		exc_valid = 1'b0;
		excp_flags = '0;
		d_write = 1'b0;
		wait_entry_done();
		check("epc", epc, pc1 - 32'd4);
		read_check(CP0_BAD_VADDR, bad);
		read_check(CP0_EPC, pc1 - 32'd4);
		read_word(CP0_CAUSE, v);
		check("cause exc_code", (v >> 2) & 32'h1f, 5);
		do_eret();
		read_check(CP0_STATUS, BEV);
	endtask

	task automatic test_interrupt();
		word_t ipc;
		ipc = lcg_next() & ~32'h3;
		// ie and im1, then iv and ip1
		mtc0_write(CP0_STATUS, BEV | 32'h0000_0201);
		mtc0_write(CP0_CAUSE, 32'h0080_0200);
		@(negedge clk);
		inter_valid = 1'b1;
		int_pc = ipc;
		int_slot = 1'b0;
		#1;
		check("exc_taken", exc_taken, 1);
		check("exc_code", exc_code, 0);
		check("entrance", entrance, BASE + 32'h200);
		@(negedge clk);
		inter_valid = 1'b0;
		wait_entry_done();
		check("epc", epc, ipc);
		read_check(CP0_EPC, ipc);
		read_check(CP0_STATUS, BEV | 32'h0000_0203);
		mtc0_write(CP0_CAUSE, 32'h0);
		mtc0_write(CP0_STATUS, BEV);
	endtask

	task automatic test_tlb();
		word_t ehi;
		word_t lo0;
		word_t lo1;
		word_t idx;
		word_t probe;
		int busy_cycles;
		ehi = lcg_next();
		lo0 = lcg_next();
		lo1 = lcg_next();
		idx = lcg_next();
		probe = lcg_next();
		@(negedge clk);
		tlb_valid = 1'b1;
		tlb_op = TLB_R;
		res_entry_hi = ehi;
		res_entry_lo0 = lo0;
		res_entry_lo1 = lo1;
		// mtc0 arrives while the three writes are queued
		@(negedge clk);
		tlb_valid = 1'b0;
		tlb_op = TLB_NONE;
		mtc0_valid = 1'b1;
		mtc0_addr = CP0_INDEX;
		mtc0_data = idx;
		#1;
		check("mtc0_stall", mtc0_stall, 0);
		check("tlb_busy", tlb_busy, 1);
		busy_cycles = 1;
		@(negedge clk);
		mtc0_valid = 1'b0;
		#1;
		while (tlb_busy) begin
			busy_cycles++;
			@(negedge clk);
			#1;
		end
		// three writes plus the cycle lost to mtc0
		check("tlb_busy cycles", busy_cycles, 4);
		read_check(CP0_INDEX, idx);
		read_check(CP0_ENTRY_HI, ehi);
		read_check(CP0_ENTRY_LO0, lo0);
		read_check(CP0_ENTRY_LO1, lo1);
		@(negedge clk);
		tlb_valid = 1'b1;
		tlb_op = TLB_P;
		res_index = probe;
		@(negedge clk);
		tlb_valid = 1'b0;
		tlb_op = TLB_NONE;
		while (tlb_busy) begin
			@(negedge clk);
		end
		read_check(CP0_INDEX, probe);
	endtask

	task automatic test_timer();
		word_t cnt;
		word_t ipc;
		int waited;
		ipc = lcg_next() & ~32'h3;
		// ie and im7
		mtc0_write(CP0_STATUS, BEV | 32'h0000_8001);
		read_word(CP0_COUNT, cnt);
		mtc0_write(CP0_COMPARE, cnt + 32'd6);
		@(negedge clk);
		inter_valid = 1'b1;
		int_pc = ipc;
		#1;
		waited = 0;
		while (!exc_taken) begin
			waited++;
			if (waited > 20) begin
				fail_now("timer interrupt was not taken within 20 cycles");
			end
			@(negedge clk);
			#1;
		end
		check("exc_code", exc_code, 0);
		check("entrance", entrance, BASE + 32'h180);
		@(negedge clk);
		inter_valid = 1'b0;
		wait_entry_done();
		check("epc", epc, ipc);
		read_check(CP0_EPC, ipc);
		read_check(CP0_CAUSE, 32'h4000_0000);
		mtc0_write(CP0_COMPARE, cnt + 32'h1000);
		read_check(CP0_CAUSE, 32'h0);
		do_eret();
		read_check(CP0_STATUS, BEV | 32'h0000_8001);
		// source is gone, nothing may be taken now
		repeat (20) begin
			@(negedge clk);
			inter_valid = 1'b1;
			#1;
			check("exc_taken", exc_taken, 0);
		end
		@(negedge clk);
		inter_valid = 1'b0;
	endtask

	initial begin
		lcg_state = 32'h345f_03b1;
		mtc0_valid = 1'b0;
		mtc0_addr = '0;
		mtc0_data = '0;
		rd_addr = '0;
		rdm_addr = '0;
		exc_valid = 1'b0;
		excp_flags = '0;
		pc = '0;
		vaddr = '0;
		is_slot = 1'b0;
		d_write = 1'b0;
		eret = 1'b0;
		ext_int = '0;
		inter_valid = 1'b0;
		int_pc = '0;
		int_slot = 1'b0;
		tlb_valid = 1'b0;
		tlb_op = TLB_NONE;
		res_index = '0;
		res_entry_hi = '0;
		res_entry_lo0 = '0;
		res_entry_lo1 = '0;
		@(negedge clk);
		while (reset) begin
			@(negedge clk);
		end
		#1;
		check("exc_busy", exc_busy, 0);
		check("tlb_busy", tlb_busy, 0);
		check("mtc0_stall", mtc0_stall, 0);
		read_check(CP0_STATUS, BEV);
		test_mtc0_read();
		test_exception();
		test_interrupt();
		test_tlb();
		test_timer();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD = 8.0,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== cp0_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
	parameter cp0_pkg::word_t EXC_BASE = 32'hbfc0_0200,
	parameter int COUNT_DIV = 2
) (
	input logic clk,
	input logic reset,
	input logic mtc0_valid,
	input cp0_pkg::cp0_addr_t mtc0_addr,
	input cp0_pkg::word_t mtc0_data,
	input cp0_pkg::cp0_addr_t rd_addr,
	input cp0_pkg::cp0_addr_t rdm_addr,
	input logic exc_valid,
	input cp0_pkg::excp_flags_t excp_flags,
	input cp0_pkg::word_t pc,
	input cp0_pkg::word_t vaddr,
	input logic is_slot,
	input logic d_write,
	input logic eret,
	input logic [5:0] ext_int,
	input logic inter_valid,
	input cp0_pkg::word_t int_pc,
	input logic int_slot,
	input logic tlb_valid,
	input cp0_pkg::tlb_op_t tlb_op,
	input cp0_pkg::word_t res_index,
	input cp0_pkg::word_t res_entry_hi,
	input cp0_pkg::word_t res_entry_lo0,
	input cp0_pkg::word_t res_entry_lo1,
	output cp0_pkg::word_t rd_data,
	output cp0_pkg::word_t rdm_data,
	output cp0_pkg::word_t epc,
	output cp0_pkg::word_t entrance,
	output cp0_pkg::exc_code_t exc_code,
	output logic exc_taken,
	output logic exc_busy,
	output logic tlb_busy,
	output logic mtc0_stall
);
	import cp0_pkg::*;

	logic bus_we;
	logic bus_from_mtc0;
	cp0_addr_t bus_addr;
	word_t bus_data;
	wr_mask_t bus_mask;
	word_t status;
	word_t cause;
	logic timer_int;
	logic exc_req;
	cp0_addr_t exc_addr;
	word_t exc_data;
	wr_mask_t exc_mask;
	logic grant_exc;
	logic tlb_req;
	cp0_addr_t tlb_addr;
	word_t tlb_data;
	wr_mask_t tlb_mask;
	logic grant_tlb;

	cp0_regfile #(
		.COUNT_DIV(COUNT_DIV)
	) i_regfile (
		.clk(clk),
		.reset(reset),
		.bus_we(bus_we),
		.bus_from_mtc0(bus_from_mtc0),
		.bus_addr(bus_addr),
		.bus_data(bus_data),
		.bus_mask(bus_mask),
		.rd_addr(rd_addr),
		.rdm_addr(rdm_addr),
		.rd_data(rd_data),
		.rdm_data(rdm_data),
		.status(status),
		.cause(cause),
		.epc(epc),
		// no consumer at this level, the tlb array sits outside
		.entry_hi(),
		.timer_int(timer_int)
	);

	cp0_write_arbiter i_arbiter (
		.exc_req(exc_req),
		.exc_addr(exc_addr),
		.exc_data(exc_data),
		.exc_mask(exc_mask),
		.mtc0_valid(mtc0_valid),
		.mtc0_addr(mtc0_addr),
		.mtc0_data(mtc0_data),
		.tlb_req(tlb_req),
		.tlb_addr(tlb_addr),
		.tlb_data(tlb_data),
		.tlb_mask(tlb_mask),
		.grant_exc(grant_exc),
		.grant_tlb(grant_tlb),
		.mtc0_stall(mtc0_stall),
		.bus_we(bus_we),
		.bus_from_mtc0(bus_from_mtc0),
		.bus_addr(bus_addr),
		.bus_data(bus_data),
		.bus_mask(bus_mask)
	);

	exc_entry #(
		.EXC_BASE(EXC_BASE)
	) i_exc_entry (
		.clk(clk),
		.reset(reset),
		.exc_valid(exc_valid),
		.excp_flags(excp_flags),
		.pc(pc),
		.vaddr(vaddr),
		.is_slot(is_slot),
		.d_write(d_write),
		.eret(eret),
		.ext_int(ext_int),
		.inter_valid(inter_valid),
		.int_pc(int_pc),
		.int_slot(int_slot),
		.status(status),
		.cause(cause),
		.timer_int(timer_int),
		.grant(grant_exc),
		.req(exc_req),
		.addr(exc_addr),
		.data(exc_data),
		.mask(exc_mask),
		.exc_taken(exc_taken),
		.exc_busy(exc_busy),
		.exc_code(exc_code),
		.entrance(entrance)
	);

	tlb_result_writer i_tlb_writer (
		.clk(clk),
		.reset(reset),
		.tlb_valid(tlb_valid),
		.tlb_op(tlb_op),
		.res_index(res_index),
		.res_entry_hi(res_entry_hi),
		.res_entry_lo0(res_entry_lo0),
		.res_entry_lo1(res_entry_lo1),
		.grant(grant_tlb),
		.req(tlb_req),
		.addr(tlb_addr),
		.data(tlb_data),
		.mask(tlb_mask),
		.tlb_busy(tlb_busy)
	);

endmodule

`default_nettype wire

// ==== tlb_result_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_result_writer (
	input logic clk,
	input logic reset,
	input logic tlb_valid,
	input cp0_pkg::tlb_op_t tlb_op,
	input cp0_pkg::word_t res_index,
	input cp0_pkg::word_t res_entry_hi,
	input cp0_pkg::word_t res_entry_lo0,
	input cp0_pkg::word_t res_entry_lo1,
	input logic grant,
	output logic req,
	output cp0_pkg::cp0_addr_t addr,
	output cp0_pkg::word_t data,
	output cp0_pkg::wr_mask_t mask,
	output logic tlb_busy
);
	import cp0_pkg::*;

	tlb_op_t op_q;
	word_t index_q;
	word_t ehi_q;
	word_t lo0_q;
	word_t lo1_q;
	// writes still to go
	logic [1:0] left;
	logic start;

	assign tlb_busy = (left != 2'd0);
	assign start = tlb_valid && !tlb_busy && (tlb_op != TLB_NONE);
	assign req = tlb_busy;
	assign mask = '1;

	always_ff @(posedge clk) begin
		if (reset) begin
			left <= 2'd0;
		end else if (start) begin
			left <= (tlb_op == TLB_P) ? 2'd1 : 2'd3;
		end else if (grant) begin
			left <= left - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			op_q <= tlb_op;
			index_q <= res_index;
			ehi_q <= res_entry_hi;
			lo0_q <= res_entry_lo0;
			lo1_q <= res_entry_lo1;
		end
	end

	// tlbr order is entryhi, entrylo0, entrylo1
	always_comb begin
		addr = CP0_INDEX;
		data = index_q;
		if (op_q == TLB_R) begin
			case (left)
				2'd3: begin
					addr = CP0_ENTRY_HI;
					data = ehi_q;
				end
				2'd2: begin
					addr = CP0_ENTRY_LO0;
					data = lo0_q;
				end
				default: begin
					addr = CP0_ENTRY_LO1;
					data = lo1_q;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== exc_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_entry #(
	parameter cp0_pkg::word_t EXC_BASE = 32'hbfc0_0200
) (
	input logic clk,
	input logic reset,
	input logic exc_valid,
	input cp0_pkg::excp_flags_t excp_flags,
	input cp0_pkg::word_t pc,
	input cp0_pkg::word_t vaddr,
	input logic is_slot,
	input logic d_write,
	input logic eret,
	input logic [5:0] ext_int,
	input logic inter_valid,
	input cp0_pkg::word_t int_pc,
	input logic int_slot,
	input cp0_pkg::word_t status,
	input cp0_pkg::word_t cause,
	input logic timer_int,
	input logic grant,
	output logic req,
	output cp0_pkg::cp0_addr_t addr,
	output cp0_pkg::word_t data,
	output cp0_pkg::wr_mask_t mask,
	output logic exc_taken,
	output logic exc_busy,
	output cp0_pkg::exc_code_t exc_code,
	output cp0_pkg::word_t entrance
);
	import cp0_pkg::*;

	typedef enum logic [2:0] {IDLE, W_CAUSE, W_EPC, W_BADVA, W_EHI, W_STATUS} state_t;

	localparam wr_mask_t MASK_EXL = 32'd1 << ST_EXL;
	localparam wr_mask_t MASK_CODE = 32'h0000_007c;
	localparam wr_mask_t MASK_VPN2 = 32'hffff_e000;

	state_t state;
	state_t tail;
	exc_code_t flag_code;
	logic from_fetch;
	logic refill;
	logic is_tlb;
	logic [7:0] int_lines;
	logic int_pending;
	logic int_saved;
	logic take_int;
	logic accept;
	logic eret_pend;
	word_t offset;
	exc_code_t code_q;
	word_t epc_q;
	word_t bad_q;
	logic bd_q;
	logic skip_epc_q;
	logic need_badva_q;
	logic need_ehi_q;

	// walk the flags from the top priority down
	always_comb begin
		flag_code = EXC_INT;
		from_fetch = 1'b0;
		refill = 1'b0;
		if (excp_flags[FLG_ADEF]) begin
			flag_code = EXC_ADEL;
			from_fetch = 1'b1;
		end else if (excp_flags[FLG_RI]) begin
			flag_code = EXC_RI;
		end else if (excp_flags[FLG_ITLB]) begin
			flag_code = EXC_TLBL;
			from_fetch = 1'b1;
			refill = 1'b1;
		end else if (excp_flags[FLG_OV]) begin
			flag_code = EXC_OV;
		end else if (excp_flags[FLG_BP]) begin
			flag_code = EXC_BP;
		end else if (excp_flags[FLG_SYS]) begin
			flag_code = EXC_SYS;
		end else if (excp_flags[FLG_DTLB]) begin
			flag_code = d_write ? EXC_TLBS : EXC_TLBL;
			refill = 1'b1;
		end else if (excp_flags[FLG_DMOD]) begin
			flag_code = EXC_MOD;
		end else if (excp_flags[FLG_ADEL]) begin
			flag_code = EXC_ADEL;
		end else if (excp_flags[FLG_ADES]) begin
			flag_code = EXC_ADES;
		end
	end

	assign is_tlb = (flag_code == EXC_TLBL) || (flag_code == EXC_TLBS) || (flag_code == EXC_MOD);

	// ip7 shares its line with the timer
	assign int_lines = {ext_int[5] | timer_int, ext_int[4:0], cause[9:8]};
	assign int_pending = status[ST_IE] && !status[ST_EXL] && (|(int_lines & status[15:8]));

	assign exc_busy = (state != IDLE);
	assign take_int = (int_pending || int_saved) && inter_valid && !exc_busy;
	assign accept = take_int || (exc_valid && !exc_busy);
	assign exc_taken = accept;
	assign exc_code = take_int ? EXC_INT : flag_code;

	always_comb begin
		offset = 32'h180;
		if (take_int) begin
			if (cause[CA_IV]) begin
				offset = 32'h200;
			end
		end else if (refill && !status[ST_EXL]) begin
			offset = '0;
		end
	end

	assign entrance = EXC_BASE + offset;
	assign tail = need_badva_q ? W_BADVA : (need_ehi_q ? W_EHI : W_STATUS);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			int_saved <= 1'b0;
			eret_pend <= 1'b0;
		end else begin
			if (accept) begin
				state <= W_CAUSE;
			end else if (grant) begin
				case (state)
					W_CAUSE:  state <= skip_epc_q ? tail : W_EPC;
					W_EPC:    state <= tail;
					W_BADVA:  state <= need_ehi_q ? W_EHI : W_STATUS;
					W_EHI:    state <= W_STATUS;
					default:  state <= IDLE;
				endcase
			end
			if (take_int || status[ST_EXL]) begin
				int_saved <= 1'b0;
			end else if (int_pending && !inter_valid && !exc_busy) begin
				int_saved <= 1'b1;
			end
			if (eret) begin
				eret_pend <= 1'b1;
			end else if (state == IDLE && grant) begin
				eret_pend <= 1'b0;
			end
		end
	end

	// event snapshot for the write sequence
	always_ff @(posedge clk) begin
		if (accept) begin
			code_q <= exc_code;
			skip_epc_q <= status[ST_EXL];
			bd_q <= take_int ? int_slot : is_slot;
			if (take_int) begin
				epc_q <= int_slot ? int_pc - 32'd4 : int_pc;
			end else begin
				epc_q <= is_slot ? pc - 32'd4 : pc;
			end
			bad_q <= from_fetch ? pc : vaddr;
			need_badva_q <= !take_int && (is_tlb || flag_code == EXC_ADEL || flag_code == EXC_ADES);
			need_ehi_q <= !take_int && is_tlb;
		end
	end

	always_comb begin
		req = 1'b1;
		addr = CP0_STATUS;
		data = '0;
		mask = MASK_EXL;
		case (state)
			W_CAUSE: begin
				addr = CP0_CAUSE;
				data[CA_BD] = bd_q;
				data[6:2] = code_q;
				// bd is left alone for a nested exception
				mask = skip_epc_q ? MASK_CODE : (MASK_CODE | (32'd1 << CA_BD));
			end
			W_EPC: begin
				addr = CP0_EPC;
				data = epc_q;
				mask = '1;
			end
			W_BADVA: begin
				addr = CP0_BAD_VADDR;
				data = bad_q;
				mask = '1;
			end
			W_EHI: begin
				addr = CP0_ENTRY_HI;
				data = bad_q;
				mask = MASK_VPN2;
			end
			W_STATUS: data[ST_EXL] = 1'b1;
			default: req = eret_pend;
		endcase
	end

endmodule

`default_nettype wire

// ==== cp0_write_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_write_arbiter (
	input logic exc_req,
	input cp0_pkg::cp0_addr_t exc_addr,
	input cp0_pkg::word_t exc_data,
	input cp0_pkg::wr_mask_t exc_mask,
	input logic mtc0_valid,
	input cp0_pkg::cp0_addr_t mtc0_addr,
	input cp0_pkg::word_t mtc0_data,
	input logic tlb_req,
	input cp0_pkg::cp0_addr_t tlb_addr,
	input cp0_pkg::word_t tlb_data,
	input cp0_pkg::wr_mask_t tlb_mask,
	output logic grant_exc,
	output logic grant_tlb,
	output logic mtc0_stall,
	output logic bus_we,
	output logic bus_from_mtc0,
	output cp0_pkg::cp0_addr_t bus_addr,
	output cp0_pkg::word_t bus_data,
	output cp0_pkg::wr_mask_t bus_mask
);
	logic grant_mtc0;

	// exception sequencer first, then mtc0, then tlb results
	assign grant_exc = exc_req;
	assign grant_mtc0 = mtc0_valid && !exc_req;
	assign grant_tlb = tlb_req && !exc_req && !mtc0_valid;
	assign mtc0_stall = mtc0_valid && !grant_mtc0;

	assign bus_we = exc_req || mtc0_valid || tlb_req;
	assign bus_from_mtc0 = grant_mtc0;

	always_comb begin
		bus_addr = exc_addr;
		bus_data = exc_data;
		bus_mask = exc_mask;
		if (grant_mtc0) begin
			bus_addr = mtc0_addr;
			bus_data = mtc0_data;
			bus_mask = '1;
		end else if (grant_tlb) begin
			bus_addr = tlb_addr;
			bus_data = tlb_data;
			bus_mask = tlb_mask;
		end
	end

endmodule

`default_nettype wire

// ==== cp0_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_regfile #(
	parameter int COUNT_DIV = 2
) (
	input logic clk,
	input logic reset,
	input logic bus_we,
	input logic bus_from_mtc0,
	input cp0_pkg::cp0_addr_t bus_addr,
	input cp0_pkg::word_t bus_data,
	input cp0_pkg::wr_mask_t bus_mask,
	input cp0_pkg::cp0_addr_t rd_addr,
	input cp0_pkg::cp0_addr_t rdm_addr,
	output cp0_pkg::word_t rd_data,
	output cp0_pkg::word_t rdm_data,
	output cp0_pkg::word_t status,
	output cp0_pkg::word_t cause,
	output cp0_pkg::word_t epc,
	output cp0_pkg::word_t entry_hi,
	output logic timer_int
);
	import cp0_pkg::*;

	localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

	word_t index_q;
	word_t entry_lo0_q;
	word_t entry_lo1_q;
	word_t bad_vaddr_q;
	word_t count_q;
	word_t entry_hi_q;
	word_t compare_q;
	word_t status_q;
	word_t cause_q;
	word_t epc_q;
	wr_mask_t eff_mask;
	logic [DIV_W-1:0] div_cnt;
	logic count_tick;
	logic count_we;
	logic compare_we;

	function automatic word_t merge(input word_t old, input word_t val, input wr_mask_t m);
		return (old & ~m) | (val & m);
	endfunction

	function automatic word_t read_reg(input cp0_addr_t a);
		case (a)
			CP0_INDEX:     return index_q;
			CP0_ENTRY_LO0: return entry_lo0_q;
			CP0_ENTRY_LO1: return entry_lo1_q;
			CP0_BAD_VADDR: return bad_vaddr_q;
			CP0_COUNT:     return count_q;
			CP0_ENTRY_HI:  return entry_hi_q;
			CP0_COMPARE:   return compare_q;
			CP0_STATUS:    return status_q;
			CP0_CAUSE:     return cause;
			CP0_EPC:       return epc_q;
			CP0_PRID:      return PRID_VALUE;
			CP0_CONFIG0:   return CONFIG0_VALUE;
			CP0_EBASE:     return EBASE_VALUE;
			default:       return '0;
		endcase
	endfunction

	// mtc0 may only touch the software writable fields
	always_comb begin
		eff_mask = bus_mask;
		if (bus_from_mtc0) begin
			if (bus_addr == CP0_STATUS) begin
				eff_mask = bus_mask & MASK_STATUS;
			end else if (bus_addr == CP0_CAUSE) begin
				eff_mask = bus_mask & MASK_CAUSE;
			end
		end
	end

	assign count_we = bus_we && (bus_addr == CP0_COUNT);
	assign compare_we = bus_we && (bus_addr == CP0_COMPARE);
	assign count_tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			count_q <= '0;
			compare_q <= COMPARE_RESET;
			status_q <= STATUS_RESET;
			cause_q <= '0;
			timer_int <= 1'b0;
		end else begin
			div_cnt <= count_tick ? '0 : div_cnt + 1'b1;
			if (count_we) begin
				count_q <= merge(count_q, bus_data, eff_mask);
			end else if (count_tick) begin
				count_q <= count_q + 1'b1;
			end
			if (compare_we) begin
				compare_q <= merge(compare_q, bus_data, eff_mask);
			end
			if (bus_we && bus_addr == CP0_STATUS) begin
				status_q <= merge(status_q, bus_data, eff_mask);
			end
			if (bus_we && bus_addr == CP0_CAUSE) begin
				cause_q <= merge(cause_q, bus_data, eff_mask);
			end
			// match stays set until compare is rewritten
			if (compare_we) begin
				timer_int <= 1'b0;
			end else if (count_q == compare_q) begin
				timer_int <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus_we) begin
			case (bus_addr)
				CP0_INDEX:     index_q <= merge(index_q, bus_data, eff_mask);
				CP0_ENTRY_LO0: entry_lo0_q <= merge(entry_lo0_q, bus_data, eff_mask);
				CP0_ENTRY_LO1: entry_lo1_q <= merge(entry_lo1_q, bus_data, eff_mask);
				CP0_BAD_VADDR: bad_vaddr_q <= merge(bad_vaddr_q, bus_data, eff_mask);
				CP0_ENTRY_HI:  entry_hi_q <= merge(entry_hi_q, bus_data, eff_mask);
				CP0_EPC:       epc_q <= merge(epc_q, bus_data, eff_mask);
				default: ;
			endcase
		end
	end

	always_comb begin
		cause = cause_q;
		cause[CA_TI] = timer_int;
	end

	assign status = status_q;
	assign epc = epc_q;
	assign entry_hi = entry_hi_q;

	// both ports see register state only, no same cycle bypass
	always_comb begin
		rd_data = read_reg(rd_addr);
		rdm_data = read_reg(rdm_addr);
	end

endmodule

`default_nettype wire

// ==== cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

	typedef logic [31:0] word_t;
	// register number in [7:3], select in [2:0]
	typedef logic [7:0] cp0_addr_t;
	typedef logic [4:0] exc_code_t;
	typedef logic [9:0] excp_flags_t;
	typedef logic [31:0] wr_mask_t;

	typedef enum logic [1:0] {
		TLB_NONE,
		TLB_P,
		TLB_R
	} tlb_op_t;

	localparam cp0_addr_t CP0_INDEX     = {5'd0, 3'd0};
	localparam cp0_addr_t CP0_ENTRY_LO0 = {5'd2, 3'd0};
	localparam cp0_addr_t CP0_ENTRY_LO1 = {5'd3, 3'd0};
	localparam cp0_addr_t CP0_BAD_VADDR = {5'd8, 3'd0};
	localparam cp0_addr_t CP0_COUNT     = {5'd9, 3'd0};
	localparam cp0_addr_t CP0_ENTRY_HI  = {5'd10, 3'd0};
	localparam cp0_addr_t CP0_COMPARE   = {5'd11, 3'd0};
	localparam cp0_addr_t CP0_STATUS    = {5'd12, 3'd0};
	localparam cp0_addr_t CP0_CAUSE     = {5'd13, 3'd0};
	localparam cp0_addr_t CP0_EPC       = {5'd14, 3'd0};
	localparam cp0_addr_t CP0_PRID      = {5'd15, 3'd0};
	localparam cp0_addr_t CP0_CONFIG0   = {5'd16, 3'd0};
	localparam cp0_addr_t CP0_EBASE     = {5'd15, 3'd1};

	localparam exc_code_t EXC_INT  = 5'd0;
	localparam exc_code_t EXC_MOD  = 5'd1;
	localparam exc_code_t EXC_TLBL = 5'd2;
	localparam exc_code_t EXC_TLBS = 5'd3;
	localparam exc_code_t EXC_ADEL = 5'd4;
	localparam exc_code_t EXC_ADES = 5'd5;
	localparam exc_code_t EXC_SYS  = 5'd8;
	localparam exc_code_t EXC_BP   = 5'd9;
	localparam exc_code_t EXC_RI   = 5'd10;
	localparam exc_code_t EXC_OV   = 5'd12;

	// flag bit positions, msb has the highest priority
	localparam int FLG_ADEF = 9;
	localparam int FLG_RI   = 8;
	localparam int FLG_ITLB = 7;
	localparam int FLG_OV   = 6;
	localparam int FLG_BP   = 5;
	localparam int FLG_SYS  = 4;
	localparam int FLG_DTLB = 3;
	localparam int FLG_DMOD = 2;
	localparam int FLG_ADEL = 1;
	localparam int FLG_ADES = 0;

	// status and cause field positions
	localparam int ST_IE  = 0;
	localparam int ST_EXL = 1;
	localparam int CA_IV  = 23;
	localparam int CA_TI  = 30;
	localparam int CA_BD  = 31;

	localparam word_t PRID_VALUE    = 32'h0000_4220;
	localparam word_t CONFIG0_VALUE = 32'h8000_0480;
	localparam word_t EBASE_VALUE   = 32'h8000_0000;
	localparam word_t STATUS_RESET  = 32'h0040_0000;
	// far from count so the timer stays quiet after reset
	localparam word_t COMPARE_RESET = 32'hffff_ffff;

	// cu0, bev, im, um, erl, exl, ie
	localparam wr_mask_t MASK_STATUS = 32'h1040_ff17;
	// iv and the two software ip bits
	localparam wr_mask_t MASK_CAUSE  = 32'h0080_0300;

endpackage

`default_nettype wire
